// ==== build.f ====
design/cmd_pkg.sv
design/frame_parser.sv
design/loopback_engine.sv
design/register_engine.sv
design/stream_merge.sv
design/command_top.sv
verification/stream_merge_chk.sv
verification/command_top_tb.sv

// ==== design/cmd_pkg.sv ====
`default_nettype none

////////////////////////////////////////////////////////////
// shared types and codes for the command executor
////////////////////////////////////////////////////////////

package cmd_pkg;

	// stream word
	localparam int WORD_W = 32;             // rx and tx data width
	typedef logic [WORD_W-1:0] word_t;      // one stream word

	// command code, low bits of the command word
	localparam int CODE_W = 5;
	typedef logic [CODE_W-1:0] code_t;

	// supported commands
	localparam code_t CC_LOOPBACK = 5'd1;   // echo payload back
	localparam code_t CC_RD_REG   = 5'd2;   // read one register
	localparam code_t CC_WR_REG   = 5'd3;   // write one register

	// reply constants
	// an illegal register number is answered with the command word xor'ed by this mask
	localparam word_t INV_MASK = {WORD_W{1'b1}};

endpackage

`default_nettype wire

// ==== design/command_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_top #(
	parameter int NUM_REGS = 8
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire cmd_pkg::word_t rx_tdata,
	input  wire                 rx_tvalid,
	input  wire                 rx_tlast,
	output logic                rx_tready,
	output cmd_pkg::word_t      tx_tdata,
	output logic                tx_tvalid,
	output logic                tx_tlast,
	input  wire                 tx_tready
);

	cmd_pkg::word_t serial_num, cmd_word;  // held frame header
	cmd_pkg::word_t word_lb, word_reg;
	wire            rx_ready_parse, rx_ready_lb, rx_ready_reg;
	wire            run_loopback, run_rd_reg, run_wr_reg;
	wire            valid_lb, last_lb, done_lb;
	wire            valid_reg, last_reg, done_reg;
	wire            accept, done;

	////////////////////////////////////////////////////////////
	// header receive and dispatch
	frame_parser u_parser (
		.clk(clk), .reset(reset),
		.rx_tdata(rx_tdata), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast),
		.rx_ready_parse(rx_ready_parse),
		.serial_num(serial_num), .cmd_word(cmd_word),
		.run_loopback(run_loopback), .run_rd_reg(run_rd_reg), .run_wr_reg(run_wr_reg),
		.done(done)
	);

	// command engines
	loopback_engine u_loopback (
		.clk(clk), .reset(reset), .run_loopback(run_loopback),
		.serial_num(serial_num), .cmd_word(cmd_word),
		.rx_tdata(rx_tdata), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast),
		.rx_ready_lb(rx_ready_lb), .accept(accept),
		.word_lb(word_lb), .valid_lb(valid_lb), .last_lb(last_lb), .done_lb(done_lb)
	);

	register_engine #(.NUM_REGS(NUM_REGS)) u_register (
		.clk(clk), .reset(reset), .run_rd_reg(run_rd_reg), .run_wr_reg(run_wr_reg),
		.serial_num(serial_num), .cmd_word(cmd_word),
		.rx_tdata(rx_tdata), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast),
		.rx_ready_reg(rx_ready_reg), .accept(accept),
		.word_reg(word_reg), .valid_reg(valid_reg), .last_reg(last_reg), .done_reg(done_reg)
	);

	// tx output stage
	stream_merge u_merge (
		.clk(clk), .reset(reset),
		.rx_ready_parse(rx_ready_parse), .rx_ready_lb(rx_ready_lb),
		.rx_ready_reg(rx_ready_reg), .rx_tready(rx_tready),
		.word_lb(word_lb), .valid_lb(valid_lb), .last_lb(last_lb),
		.word_reg(word_reg), .valid_reg(valid_reg), .last_reg(last_reg),
		.accept(accept), .done_lb(done_lb), .done_reg(done_reg), .done(done),
		.tx_tdata(tx_tdata), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tready(tx_tready)
	);

endmodule

`default_nettype wire

// ==== design/frame_parser.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_parser (
	input  wire                 clk,
	input  wire                 reset,
	input  wire cmd_pkg::word_t rx_tdata,
	input  wire                 rx_tvalid,
	input  wire                 rx_tlast,
	output logic                rx_ready_parse,  // parser owns rx in header and drain states
	output cmd_pkg::word_t      serial_num,      // held until next frame
	output cmd_pkg::word_t      cmd_word,        // held until next frame
	output logic                run_loopback,
	output logic                run_rd_reg,
	output logic                run_wr_reg,
	input  wire                 done             // merged done from the engines
);

	localparam logic [2:0] S_SERIAL   = 3'd0;  // waiting for word 0
	localparam logic [2:0] S_COMMAND  = 3'd1;  // waiting for word 1
	localparam logic [2:0] S_DISPATCH = 3'd2;  // one cycle, run pulse goes out
	localparam logic [2:0] S_WAIT     = 3'd3;  // an engine owns the frame
	localparam logic [2:0] S_DRAIN    = 3'd4;  // unknown code, throw away to tlast

	logic [2:0]     state;
	logic           cmd_last;  // the command word closed its frame
	cmd_pkg::code_t code;
	logic           known;

	assign code  = cmd_word[cmd_pkg::CODE_W-1:0];
	assign known = (code == cmd_pkg::CC_LOOPBACK) || (code == cmd_pkg::CC_RD_REG) ||
		(code == cmd_pkg::CC_WR_REG);

	assign rx_ready_parse = (state == S_SERIAL) || (state == S_COMMAND) || (state == S_DRAIN);

	// decode only in dispatch, so every run line is a single-cycle pulse
	assign run_loopback = (state == S_DISPATCH) && (code == cmd_pkg::CC_LOOPBACK);
	assign run_rd_reg   = (state == S_DISPATCH) && (code == cmd_pkg::CC_RD_REG);
	assign run_wr_reg   = (state == S_DISPATCH) && (code == cmd_pkg::CC_WR_REG);

	// header registers
	always_ff @(posedge clk) begin
		if (state == S_SERIAL && rx_tvalid)
			serial_num <= rx_tdata;
		if (state == S_COMMAND && rx_tvalid) begin
			cmd_word <= rx_tdata;
			cmd_last <= rx_tlast;   // tells dispatch whether there is anything left to drain
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= S_SERIAL;
		end else begin
			case (state)
			S_SERIAL: begin
				if (rx_tvalid && !rx_tlast)   // a one-word frame is a runt, drop it
					state <= S_COMMAND;
			end
			S_COMMAND: begin
				if (rx_tvalid)
					state <= S_DISPATCH;
			end
			S_DISPATCH: begin
				if (known)
					state <= S_WAIT;
				else if (cmd_last)
					state <= S_SERIAL;    // unknown and already at tlast, nothing to drain
				else
					state <= S_DRAIN;
			end
			S_WAIT: begin
				if (done)
					state <= S_SERIAL;
			end
			S_DRAIN: begin
				if (rx_tvalid && rx_tlast)
					state <= S_SERIAL;
			end
			default: state <= S_SERIAL;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/loopback_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module loopback_engine (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 run_loopback,
	input  wire cmd_pkg::word_t serial_num,
	input  wire cmd_pkg::word_t cmd_word,
	input  wire cmd_pkg::word_t rx_tdata,
	input  wire                 rx_tvalid,
	input  wire                 rx_tlast,
	output logic                rx_ready_lb,
	input  wire                 accept,      // merge stage can take a word this cycle
	output cmd_pkg::word_t      word_lb,
	output logic                valid_lb,
	output logic                last_lb,
	output logic                done_lb
);

	localparam logic [1:0] L_IDLE   = 2'd0;
	localparam logic [1:0] L_SERIAL = 2'd1;
	localparam logic [1:0] L_CMD    = 2'd2;
	localparam logic [1:0] L_DATA   = 2'd3;  // payload words go straight through

	logic [1:0] state;
	logic       prev_tlast;  // rx tlast seen at the previous edge
	logic       empty;       // frame had no payload

	// run comes exactly one cycle after the parser took the command word,
	// so prev_tlast is that word's tlast when run is high
	always_ff @(posedge clk) begin
		if (reset)
			prev_tlast <= 1'b0;
		else
			prev_tlast <= rx_tvalid && rx_tlast;
	end

	always_ff @(posedge clk) begin
		if (state == L_IDLE && run_loopback)
			empty <= prev_tlast;
	end

	// pull from rx only when the merge stage takes the word in the same cycle
	assign rx_ready_lb = (state == L_DATA) && accept;

	always_comb begin
		word_lb  = rx_tdata;
		valid_lb = 1'b0;
		last_lb  = 1'b0;
		case (state)
		L_SERIAL: begin
			word_lb  = serial_num;
			valid_lb = 1'b1;
		end
		L_CMD: begin
			word_lb  = cmd_word;
			valid_lb = 1'b1;
			last_lb  = empty;       // two-word reply ends here
		end
		L_DATA: begin
			valid_lb = rx_tvalid;
			last_lb  = rx_tlast;
		end
		default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state   <= L_IDLE;
			done_lb <= 1'b0;
		end else begin
			done_lb <= 1'b0;
			case (state)
			L_IDLE: begin
				if (run_loopback)
					state <= L_SERIAL;
			end
			L_SERIAL: begin
				if (accept)
					state <= L_CMD;
			end
			L_CMD: begin
				if (accept && empty) begin
					state   <= L_IDLE;
					done_lb <= 1'b1;
				end else if (accept) begin
					state <= L_DATA;
				end
			end
			L_DATA: begin
				if (accept && rx_tvalid && rx_tlast) begin   // last echoed word sent
					state   <= L_IDLE;
					done_lb <= 1'b1;
				end
			end
			default: state <= L_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/register_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_engine #(
	parameter int NUM_REGS = 8
) (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 run_rd_reg,
	input  wire                 run_wr_reg,
	input  wire cmd_pkg::word_t serial_num,
	input  wire cmd_pkg::word_t cmd_word,
	input  wire cmd_pkg::word_t rx_tdata,
	input  wire                 rx_tvalid,
	input  wire                 rx_tlast,
	output logic                rx_ready_reg,
	input  wire                 accept,
	output cmd_pkg::word_t      word_reg,
	output logic                valid_reg,
	output logic                last_reg,
	output logic                done_reg
);

	localparam int IDX_W = (NUM_REGS > 1) ? $clog2(NUM_REGS) : 1;

	localparam logic [2:0] R_IDLE   = 3'd0;
	localparam logic [2:0] R_NUM    = 3'd1;  // take register number word
	localparam logic [2:0] R_DATA   = 3'd2;  // take write data word
	localparam logic [2:0] R_SERIAL = 3'd3;
	localparam logic [2:0] R_CMD    = 3'd4;  // command or inverted command
	localparam logic [2:0] R_VALUE  = 3'd5;  // read data, legal reads only

	logic [2:0]       state;
	logic             is_wr;      // current request is a write
	logic [IDX_W-1:0] reg_idx;    // latched register number
	logic             illegal;    // latched number is out of range
	logic             num_ok;
	logic             frame_end;  // reply stops after the command word
	cmd_pkg::word_t   regs [NUM_REGS];

	assign num_ok    = rx_tdata < cmd_pkg::WORD_W'(NUM_REGS);
	assign frame_end = illegal || is_wr;

	assign rx_ready_reg = (state == R_NUM) || (state == R_DATA);

	////////////////////////////////////////////////////////////
	// register bank
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
		end else if (state == R_DATA && rx_tvalid && !illegal) begin
			regs[reg_idx] <= rx_tdata;
		end
	end

	// number latch, the low bits are enough once the range check passed
	always_ff @(posedge clk) begin
		if (state == R_NUM && rx_tvalid) begin
			reg_idx <= rx_tdata[IDX_W-1:0];
			illegal <= !num_ok;
		end
	end

	////////////////////////////////////////////////////////////
	// reply words
	always_comb begin
		word_reg  = serial_num;
		valid_reg = 1'b0;
		last_reg  = 1'b0;
		case (state)
		R_SERIAL: valid_reg = 1'b1;
		R_CMD: begin
			word_reg  = illegal ? (cmd_word ^ cmd_pkg::INV_MASK) : cmd_word;
			valid_reg = 1'b1;
			last_reg  = frame_end;
		end
		R_VALUE: begin
			word_reg  = regs[reg_idx];
			valid_reg = 1'b1;
			last_reg  = 1'b1;
		end
		default: ;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state    <= R_IDLE;
			is_wr    <= 1'b0;
			done_reg <= 1'b0;
		end else begin
			done_reg <= 1'b0;
			case (state)
			R_IDLE: begin
				if (run_rd_reg || run_wr_reg) begin
					state <= R_NUM;
					is_wr <= run_wr_reg;
				end
			end
			R_NUM: begin
				if (rx_tvalid && is_wr && !rx_tlast)
					state <= R_DATA;
				else if (rx_tvalid)
					state <= R_SERIAL;   // read, or a write cut short
			end
			R_DATA: begin
				if (rx_tvalid)
					state <= R_SERIAL;
			end
			R_SERIAL: begin
				if (accept)
					state <= R_CMD;
			end
			R_CMD: begin
				if (accept && frame_end) begin
					state    <= R_IDLE;
					done_reg <= 1'b1;
				end else if (accept) begin
					state <= R_VALUE;
				end
			end
			R_VALUE: begin
				if (accept) begin
					state    <= R_IDLE;
					done_reg <= 1'b1;
				end
			end
			default: state <= R_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== design/stream_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_merge (
	input  wire                 clk,
	input  wire                 reset,
	input  wire                 rx_ready_parse,
	input  wire                 rx_ready_lb,
	input  wire                 rx_ready_reg,
	output logic                rx_tready,
	input  wire cmd_pkg::word_t word_lb,
	input  wire                 valid_lb,
	input  wire                 last_lb,
	input  wire cmd_pkg::word_t word_reg,
	input  wire                 valid_reg,
	input  wire                 last_reg,
	output logic                accept,     // room in the tx register this cycle
	input  wire                 done_lb,
	input  wire                 done_reg,
	output logic                done,
	output cmd_pkg::word_t      tx_tdata,
	output logic                tx_tvalid,
	output logic                tx_tlast,
	input  wire                 tx_tready
);

	logic full;  // tx register holds a word
	logic load;

	assign rx_tready = rx_ready_parse || rx_ready_lb || rx_ready_reg;
	assign done      = done_lb || done_reg;

	// empty, or emptying on this edge
	assign accept    = !full || tx_tready;
	assign load      = accept && (valid_lb || valid_reg);
	assign tx_tvalid = full;

	always_ff @(posedge clk) begin
		if (load)
			tx_tdata <= valid_lb ? word_lb : word_reg;   // one engine at a time
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			full     <= 1'b0;
			tx_tlast <= 1'b0;
		end else if (accept) begin
			full     <= valid_lb || valid_reg;
			tx_tlast <= valid_lb ? last_lb : (valid_reg && last_reg);   // low when empty
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# compile with Verilator, run, and decide on the pass line in the output
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module command_top_tb -Mdir obj_dir -f build.f

# keep running past assertion errors so the testbench can report them
out=$(./obj_dir/Vcommand_top_tb +verilator+error+limit+100 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q '^Verification passed$'; then
	exit 0
fi
exit 1

// ==== verification/command_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module command_top_tb;

	localparam int NUM_REGS   = 8;
	localparam int IDX_W      = $clog2(NUM_REGS);
	localparam int LB_FRAMES  = 8;                                  // loopback frames per pass
	localparam int PASS_WORDS = LB_FRAMES * 7 + NUM_REGS * 13 + 18;  // worst-case rx words
	localparam int TIMEOUT    = 2 * PASS_WORDS * 40;                // cycles for both passes
	localparam cmd_pkg::word_t SEED = 32'd38;

	logic           clk, reset;
	cmd_pkg::word_t rx_tdata, tx_tdata;
	logic           rx_tvalid, rx_tlast, rx_tready;
	logic           tx_tvalid, tx_tlast, tx_tready;

	cmd_pkg::word_t req_q[$];                 // request frame being built
	logic [32:0]    exp_q[$];                 // expected {tlast, tdata}
	cmd_pkg::word_t model_regs [NUM_REGS];    // reference copy of the bank
	cmd_pkg::word_t pay_lfsr, gap_lfsr, serial_no;
	int             errors, tests, test_err0, chk_fails;
	int             replies_expected, replies_seen;
	logic           use_gaps;
	logic           hold_tx;                  // forces tx_tready low
	string          test_name;

	command_top #(.NUM_REGS(NUM_REGS)) UUT (
		.clk(clk), .reset(reset),
		.rx_tdata(rx_tdata), .rx_tvalid(rx_tvalid), .rx_tlast(rx_tlast), .rx_tready(rx_tready),
		.tx_tdata(tx_tdata), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tready(tx_tready)
	);

	always begin
		clk = 1'b0;
		#2;
		clk = 1'b1;
		#2;
	end

	// galois lfsr stepped once per bit taken
	function automatic cmd_pkg::word_t lfsr_take(inout cmd_pkg::word_t state, input int n);
		cmd_pkg::word_t bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits  = {bits[30:0], state[0]};
			state = state[0] ? ((state >> 1) ^ 32'h80200003) : (state >> 1);
		end
		return bits;
	endfunction

	////////////////////////////////////////////////////////////
	// reference model builds the expected reply of the frame in req_q
	function automatic void expect_reply();
		cmd_pkg::word_t cmd;
		cmd_pkg::word_t num;
		int             n;
		cmd = req_q[1];
		n   = req_q.size();
		case (cmd[cmd_pkg::CODE_W-1:0])
		cmd_pkg::CC_LOOPBACK: begin
			exp_q.push_back({1'b0, req_q[0]});
			exp_q.push_back({n == 2, cmd});             // no payload ends on the command
			for (int i = 2; i < n; i++)
				exp_q.push_back({i == n - 1, req_q[i]});
			replies_expected++;
		end
		cmd_pkg::CC_RD_REG, cmd_pkg::CC_WR_REG: begin
			num = req_q[2];
			exp_q.push_back({1'b0, req_q[0]});
			if (num >= NUM_REGS) begin
				exp_q.push_back({1'b1, ~cmd});          // illegal number leaves the bank untouched
			end else if (cmd[cmd_pkg::CODE_W-1:0] == cmd_pkg::CC_WR_REG) begin
				model_regs[num[IDX_W-1:0]] = req_q[3];
				exp_q.push_back({1'b1, cmd});
			end else begin
				exp_q.push_back({1'b0, cmd});
				exp_q.push_back({1'b1, model_regs[num[IDX_W-1:0]]});
			end
			replies_expected++;
		end
		default: ;   // unknown code is drained silently
		endcase
	endfunction

	task automatic check_value(input string name, input logic [32:0] expected,
		input logic [32:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("mismatch %s: expected %h actual %h", name, expected, actual);  // msb is tlast
		end
	endtask

	// collector compares every accepted tx word
	always @(posedge clk) begin
		if (!reset && tx_tvalid && tx_tready) begin
			if (exp_q.size() == 0) begin
				errors++;
				$display("test %s: reply word %h arrived when none was expected", test_name, tx_tdata);
			end else begin
				check_value(test_name, exp_q.pop_front(), {tx_tlast, tx_tdata});
			end
			if (tx_tlast)
				replies_seen <= replies_seen + 1;
		end
	end

	// tx back-pressure gives ready three cycles in four with gaps on
	initial begin
		gap_lfsr = SEED;
		tx_tready <= 1'b0;
		forever begin
			@(posedge clk);
			if (hold_tx)
				tx_tready <= 1'b0;
			else if (use_gaps)
				tx_tready <= (lfsr_take(gap_lfsr, 2) != '0);
			else
				tx_tready <= 1'b1;
		end
	end

	initial begin
		repeat (TIMEOUT) @(posedge clk);
		$display("timeout: replies still missing after %0d cycles", TIMEOUT);
		$display("Verification failed");
		$finish;
	end

	////////////////////////////////////////////////////////////
	// stimulus
	task automatic apply_reset();
		reset <= 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		for (int r = 0; r < NUM_REGS; r++)
			model_regs[r] = '0;
	endtask

	task automatic begin_frame(input cmd_pkg::code_t code);
		cmd_pkg::word_t upper;
		upper     = lfsr_take(pay_lfsr, 27);    // random bits above the code
		serial_no = serial_no + 1;
		req_q.delete();
		req_q.push_back(serial_no);
		req_q.push_back({upper[26:0], code});
	endtask

	// present req_q on rx one word per handshake
	task automatic drive_frame();
		for (int i = 0; i < req_q.size(); i++) begin
			rx_tdata  <= req_q[i];
			rx_tvalid <= 1'b1;
			rx_tlast  <= (i == req_q.size() - 1);
			@(posedge clk);
			while (!rx_tready)
				@(posedge clk);
		end
		rx_tvalid <= 1'b0;
		rx_tlast  <= 1'b0;
	endtask

	// send req_q word by word, then wait for every reply so far
	task automatic send_frame();
		expect_reply();
		drive_frame();
		while (replies_seen != replies_expected)
			@(posedge clk);
	endtask

	// reset lands while a reply word waits in the tx register
	task automatic reset_mid_reply();
		begin_frame(cmd_pkg::CC_LOOPBACK);   // two-word frame whose reply is cut off
		hold_tx <= 1'b1;
		drive_frame();
		while (!tx_tvalid)
			@(posedge clk);
		apply_reset();
		hold_tx <= 1'b0;
	endtask

	task automatic start_test(input string name);
		if (use_gaps)
			test_name = {name, " with gaps"};
		else
			test_name = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == test_err0)
			$display("test %s: ok", test_name);
		else
			$display("test %s: %0d errors", test_name, errors - test_err0);
	endtask

	task automatic read_all();
		for (int r = 0; r < NUM_REGS; r++) begin
			begin_frame(cmd_pkg::CC_RD_REG);
			req_q.push_back(cmd_pkg::word_t'(r));
			send_frame();
		end
	endtask

	task automatic echo_frames();
		start_test("loopback");
		for (int i = 0; i < LB_FRAMES; i++) begin
			begin_frame(cmd_pkg::CC_LOOPBACK);
			for (int k = 0; k < i % 6; k++)     // payload of 0 to 5 words
				req_q.push_back(lfsr_take(pay_lfsr, 32));
			send_frame();
		end
		end_test();
	endtask

	task automatic read_after_reset();
		start_test("read after reset");
		read_all();
		end_test();
	endtask

	task automatic write_then_read();
		start_test("write then read");
		for (int r = 0; r < NUM_REGS; r++) begin
			begin_frame(cmd_pkg::CC_WR_REG);
			req_q.push_back(cmd_pkg::word_t'(r));
			req_q.push_back(lfsr_take(pay_lfsr, 32));
			send_frame();
			begin_frame(cmd_pkg::CC_RD_REG);
			req_q.push_back(cmd_pkg::word_t'(r));
			send_frame();
		end
		end_test();
	endtask

	task automatic illegal_numbers();
		start_test("illegal register");
		begin_frame(cmd_pkg::CC_RD_REG);
		req_q.push_back(cmd_pkg::word_t'(NUM_REGS) + lfsr_take(pay_lfsr, 4));
		send_frame();
		begin_frame(cmd_pkg::CC_WR_REG);
		req_q.push_back(cmd_pkg::word_t'(NUM_REGS) + lfsr_take(pay_lfsr, 4));
		req_q.push_back(lfsr_take(pay_lfsr, 32));
		send_frame();
		read_all();   // bank must be as before
		end_test();
	endtask

	task automatic unknown_code();
		cmd_pkg::word_t bits;
		start_test("unknown code");
		bits = lfsr_take(pay_lfsr, 4);
		begin_frame(5'd4 + {1'b0, bits[3:0]});   // codes 4 to 19
		req_q.push_back(lfsr_take(pay_lfsr, 32));
		req_q.push_back(lfsr_take(pay_lfsr, 32));
		send_frame();
		begin_frame(cmd_pkg::CC_LOOPBACK);
		for (int k = 0; k < 5; k++)
			req_q.push_back(lfsr_take(pay_lfsr, 32));
		send_frame();
		end_test();
	endtask

	initial begin
		pay_lfsr = SEED;
		serial_no = 32'h100;
		rx_tdata  <= '0;
		rx_tvalid <= 1'b0;
		rx_tlast  <= 1'b0;
		use_gaps  <= 1'b0;
		hold_tx   <= 1'b0;
		for (int p = 0; p < 2; p++) begin
			use_gaps <= (p == 1);   // second pass repeats everything under back-pressure
			if (p == 0)
				apply_reset();
			else
				reset_mid_reply();
			echo_frames();
			read_after_reset();
			write_then_read();
			illegal_numbers();
			unknown_code();
		end
		chk_fails = UUT.u_merge.u_tx_chk.stall_errs + UUT.u_merge.u_tx_chk.reset_errs +
			UUT.u_merge.u_tx_chk.last_errs;
		$display("%0d tests, %0d errors, %0d assertion failures", tests, errors, chk_fails);
		if (errors == 0 && chk_fails == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verification/stream_merge_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module stream_merge_chk (
	input wire                 clk,
	input wire                 reset,
	input wire cmd_pkg::word_t tx_tdata,
	input wire                 tx_tvalid,
	input wire                 tx_tlast,
	input wire                 tx_tready
);

	int stall_errs;   // failure counts per property
	int reset_errs;
	int last_errs;

	// a stalled word holds data and last
	hold_on_stall: assert property (@(posedge clk) disable iff (reset)
		tx_tvalid && !tx_tready |=> $stable(tx_tdata) && $stable(tx_tlast))
	else begin
		$error("tx word changed while tx_tready was low");
		stall_errs++;
	end

	empty_after_reset: assert property (@(posedge clk) reset |=> !tx_tvalid)
	else begin
		$error("tx_tvalid high in the cycle after reset");
		reset_errs++;
	end

	last_needs_valid: assert property (@(posedge clk) disable iff (reset) tx_tlast |-> tx_tvalid)
	else begin
		$error("tx_tlast high without tx_tvalid");
		last_errs++;
	end

endmodule

bind stream_merge stream_merge_chk u_tx_chk (
	.clk(clk), .reset(reset),
	.tx_tdata(tx_tdata), .tx_tvalid(tx_tvalid), .tx_tlast(tx_tlast), .tx_tready(tx_tready)
);

`default_nettype wire
